//--- logic/sram_pkg.sv
`default_nettype none

package sram_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [23:0] addr_t;
    typedef logic [5:0]  len_t;    // Burst size, 1 to 32
    typedef logic [3:0]  led_t;    // Active low

    typedef struct packed {
        logic  write_cmd;
        logic  read_cmd;
        len_t  size;
        addr_t address;
    } cmd_t;

    // ----------------------------------------
    // SRAM command set
    // ----------------------------------------
    localparam byte_t CMD_READ  = 8'h03;
    localparam byte_t CMD_WRITE = 8'h02;
    localparam byte_t CMD_EQIO  = 8'h38;    // Enter quad I/O

    localparam int DUMMY_BYTES = 1;
    localparam int ADDR_BYTES  = 3;

    localparam int FIFO_DEPTH = 32;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // Half period of sck in pll_clk cycles
    localparam logic [11:0] SPI_DIV  = 12'd4;
    localparam logic [11:0] QUAD_DIV = 12'd2;

    localparam logic DIR_OUT = 1'b1;
    localparam logic DIR_IN  = 1'b0;

    // ----------------------------------------
    // Self-test
    // ----------------------------------------
    localparam addr_t TEST_ADDR = 24'h001122;
    localparam int    TEST_LEN  = 8;
    localparam byte_t TEST_SEED = 8'hAA;
    localparam byte_t TEST_STEP = 8'h35;

    localparam led_t LED_IDLE = 4'b1111;
    localparam led_t LED_PASS = 4'b0110;    // Finished, pass
    localparam led_t LED_FAIL = 4'b0101;    // Finished, mismatch

endpackage

`default_nettype wire

//--- logic/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo (
    input  wire                               pll_clk,
    input  wire                               rst_n,
    input  wire                               push,
    input  wire sram_pkg::byte_t              wdata,
    input  wire                               pop,
    output sram_pkg::byte_t                   rdata,
    output logic                              empty,
    output logic                              full,
    output logic [sram_pkg::FIFO_PTR_W:0]     count
);

    sram_pkg::byte_t mem [sram_pkg::FIFO_DEPTH];
    logic [sram_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [sram_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic do_push;
    logic do_pop;

    // Overflow and underflow strobes are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == (sram_pkg::FIFO_PTR_W + 1)'(sram_pkg::FIFO_DEPTH));
    assign rdata = mem[rd_ptr];    // Head shown directly

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge pll_clk) begin
        if (do_push) mem[wr_ptr] <= wdata;
    end

endmodule

`default_nettype wire

//--- logic/spi_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shifter (
    input  wire                  pll_clk,
    input  wire                  rst_n,
    input  wire                  start,
    input  wire                  quad,
    input  wire                  dir,
    input  wire sram_pkg::byte_t tx_byte,
    input  wire [3:0]            sio_in,
    output sram_pkg::byte_t      rx_byte,
    output logic                 byte_done,
    output logic                 sck,
    output logic [3:0]           sio_out,
    output logic [3:0]           sio_oe
);

    logic            busy;
    logic            quad_r;
    logic            dir_r;
    logic [11:0]     div_cnt;
    logic [11:0]     div_max;
    logic [3:0]      half_cnt;
    logic            half_end;
    logic            last_half;
    logic            launch;
    sram_pkg::byte_t shift_out;

    assign launch    = start && !busy;
    assign div_max   = (quad_r ? sram_pkg::QUAD_DIV : sram_pkg::SPI_DIV) - 12'd1;
    assign half_end  = busy && (div_cnt == div_max);
    assign last_half = (half_cnt == (quad_r ? 4'd3 : 4'd15));    // 4 or 16 edges per byte

    // ----------------------------------------
    // Pin drive, MSB first
    // ----------------------------------------
    always_comb begin
        sio_out = quad_r ? shift_out[7:4] : {3'b000, shift_out[7]};
        if (!busy || dir_r != sram_pkg::DIR_OUT) begin
            sio_oe = 4'b0000;
        end else begin
            sio_oe = quad_r ? 4'b1111 : 4'b0001;    // MOSI only in SPI mode
        end
    end

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            quad_r    <= 1'b0;
            dir_r     <= sram_pkg::DIR_IN;
            div_cnt   <= '0;
            half_cnt  <= '0;
            sck       <= 1'b0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (launch) begin
                busy     <= 1'b1;
                quad_r   <= quad;
                dir_r    <= dir;
                div_cnt  <= '0;
                half_cnt <= '0;
            end else if (busy) begin
                div_cnt <= half_end ? '0 : div_cnt + 12'd1;
                if (half_end) begin
                    sck      <= !sck;
                    half_cnt <= half_cnt + 4'd1;
                    if (last_half) begin    // Final falling edge
                        busy      <= 1'b0;
                        byte_done <= 1'b1;
                    end
                end
            end
        end
    end

    // Shift out on falling sck, sample on rising sck
    always_ff @(posedge pll_clk) begin
        if (launch) begin
            shift_out <= tx_byte;
        end else if (half_end && sck) begin
            shift_out <= quad_r ? {shift_out[3:0], 4'b0000} : {shift_out[6:0], 1'b0};
        end
        if (half_end && !sck) begin
            rx_byte <= quad_r ? {rx_byte[3:0], sio_in} : {rx_byte[6:0], sio_in[1]};
        end
    end

endmodule

`default_nettype wire

//--- logic/sram_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sram_sequencer (
    input  wire                  pll_clk,
    input  wire                  rst_n,
    input  wire sram_pkg::cmd_t  cmd,
    input  wire                  byte_done,
    input  wire sram_pkg::byte_t rx_byte,
    input  wire sram_pkg::byte_t wr_rdata,
    input  wire                  wr_empty,
    output logic                 done,
    output logic                 wr_pop,
    output logic                 rd_push,
    output sram_pkg::byte_t      rd_wdata,
    output logic                 start,
    output logic                 quad,
    output logic                 dir,
    output sram_pkg::byte_t      tx_byte,
    output logic                 cs
);

    typedef enum logic [2:0] {
        ST_BOOT, ST_IDLE, ST_CMD, ST_ADDR, ST_DUMMY, ST_WDATA, ST_RDATA, ST_CLOSE
    } state_t;

    typedef enum logic [1:0] {OP_EQIO, OP_WRITE, OP_READ} op_t;

    state_t          state;
    op_t             op;
    sram_pkg::addr_t addr_sh;
    sram_pkg::len_t  size_r;
    sram_pkg::len_t  cnt;
    logic            addr_last;
    logic            launch_wr;

    assign addr_last = (cnt == sram_pkg::len_t'(sram_pkg::ADDR_BYTES));

    // Next write byte after the address or after each data byte
    assign launch_wr = byte_done &&
        (state == ST_WDATA || (state == ST_ADDR && op == OP_WRITE && addr_last));

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            state   <= ST_BOOT;
            op      <= OP_EQIO;
            cs      <= 1'b1;
            done    <= 1'b0;
            start   <= 1'b0;
            quad    <= 1'b0;
            dir     <= sram_pkg::DIR_OUT;
            wr_pop  <= 1'b0;
            rd_push <= 1'b0;
            cnt     <= '0;
        end else begin
            start   <= 1'b0;
            wr_pop  <= 1'b0;
            rd_push <= 1'b0;
            case (state)
                ST_BOOT: begin    // EQIO on single-bit SPI
                    cs      <= 1'b0;
                    start   <= 1'b1;
                    tx_byte <= sram_pkg::CMD_EQIO;
                    state   <= ST_CMD;
                end
                ST_IDLE: begin
                    if (cmd.write_cmd || cmd.read_cmd) begin
                        done    <= 1'b0;
                        cs      <= 1'b0;
                        start   <= 1'b1;
                        dir     <= sram_pkg::DIR_OUT;
                        tx_byte <= cmd.write_cmd ? sram_pkg::CMD_WRITE : sram_pkg::CMD_READ;
                        op      <= cmd.write_cmd ? OP_WRITE : OP_READ;
                        addr_sh <= cmd.address;
                        size_r  <= cmd.size;
                        state   <= ST_CMD;
                    end
                end
                ST_CMD: begin
                    if (byte_done && op == OP_EQIO) begin
                        cs    <= 1'b1;
                        state <= ST_CLOSE;
                    end else if (byte_done) begin
                        start   <= 1'b1;
                        tx_byte <= addr_sh[23:16];
                        addr_sh <= addr_sh << 8;
                        cnt     <= 6'd1;
                        state   <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (byte_done && !addr_last) begin
                        start   <= 1'b1;
                        tx_byte <= addr_sh[23:16];    // Address MSB first
                        addr_sh <= addr_sh << 8;
                        cnt     <= cnt + 6'd1;
                    end else if (byte_done && op == OP_WRITE) begin
                        state <= ST_WDATA;
                    end else if (byte_done) begin
                        start   <= 1'b1;
                        tx_byte <= '0;
                        cnt     <= 6'd1;
                        state   <= ST_DUMMY;
                    end
                end
                ST_DUMMY: begin
                    if (byte_done) begin
                        start <= 1'b1;
                        if (cnt == sram_pkg::len_t'(sram_pkg::DUMMY_BYTES)) begin
                            dir   <= sram_pkg::DIR_IN;    // Turn the bus around
                            cnt   <= 6'd1;
                            state <= ST_RDATA;
                        end else begin
                            tx_byte <= '0;
                            cnt     <= cnt + 6'd1;
                        end
                    end
                end
                ST_RDATA: begin
                    if (byte_done) begin
                        rd_push  <= 1'b1;
                        rd_wdata <= rx_byte;
                        cnt      <= cnt + 6'd1;
                        if (cnt == size_r) begin
                            cs    <= 1'b1;
                            state <= ST_CLOSE;
                        end else begin
                            start <= 1'b1;
                        end
                    end
                end
                ST_CLOSE: begin
                    if (op == OP_EQIO) quad <= 1'b1;    // SRAM now in quad mode
                    done  <= 1'b1;
                    dir   <= sram_pkg::DIR_OUT;
                    state <= ST_IDLE;
                end
                default: begin
                    state <= state;    // ST_WDATA waits on launch_wr
                end
            endcase

            // ----------------------------------------
            // Write data, drain FIFO until empty
            // ----------------------------------------
            if (launch_wr && wr_empty) begin
                cs    <= 1'b1;
                state <= ST_CLOSE;
            end else if (launch_wr) begin
                start   <= 1'b1;
                tx_byte <= wr_rdata;
                wr_pop  <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/spi_sram.sv
`timescale 1ns/1ps
`default_nettype none

module spi_sram (
    input  wire                  pll_clk,
    input  wire                  rst_n,
    input  wire sram_pkg::cmd_t  cmd,
    input  wire sram_pkg::byte_t data_in,
    input  wire                  data_in_valid,
    input  wire                  data_out_read,
    output logic                 done,
    output sram_pkg::byte_t      data_out,
    output logic                 data_out_empty,
    output logic                 cs,
    output logic                 sck,
    inout  wire [3:0]            sio
);

    sram_pkg::byte_t wr_rdata;
    sram_pkg::byte_t rd_wdata;
    sram_pkg::byte_t tx_byte;
    sram_pkg::byte_t rx_byte;
    logic            wr_empty;
    logic            wr_pop;
    logic            rd_push;
    logic            start;
    logic            quad;
    logic            dir;
    logic            byte_done;
    logic [3:0]      sio_out;
    logic [3:0]      sio_oe;

    byte_fifo i_wr_fifo (
        .pll_clk (pll_clk),
        .rst_n   (rst_n),
        .push    (data_in_valid),
        .wdata   (data_in),
        .pop     (wr_pop),
        .rdata   (wr_rdata),
        .empty   (wr_empty),
        .full    (),
        .count   ()
    );

    byte_fifo i_rd_fifo (
        .pll_clk (pll_clk),
        .rst_n   (rst_n),
        .push    (rd_push),
        .wdata   (rd_wdata),
        .pop     (data_out_read),
        .rdata   (data_out),
        .empty   (data_out_empty),
        .full    (),
        .count   ()
    );

    sram_sequencer i_seq (
        .pll_clk   (pll_clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .byte_done (byte_done),
        .rx_byte   (rx_byte),
        .wr_rdata  (wr_rdata),
        .wr_empty  (wr_empty),
        .done      (done),
        .wr_pop    (wr_pop),
        .rd_push   (rd_push),
        .rd_wdata  (rd_wdata),
        .start     (start),
        .quad      (quad),
        .dir       (dir),
        .tx_byte   (tx_byte),
        .cs        (cs)
    );

    spi_shifter i_shift (
        .pll_clk   (pll_clk),
        .rst_n     (rst_n),
        .start     (start),
        .quad      (quad),
        .dir       (dir),
        .tx_byte   (tx_byte),
        .sio_in    (sio),
        .rx_byte   (rx_byte),
        .byte_done (byte_done),
        .sck       (sck),
        .sio_out   (sio_out),
        .sio_oe    (sio_oe)
    );

    // Tristate pads, one enable per lane
    for (genvar i = 0; i < 4; i++) begin : g_sio
        assign sio[i] = sio_oe[i] ? sio_out[i] : 1'bz;
    end

endmodule

`default_nettype wire

//--- logic/sram_selftest.sv
`timescale 1ns/1ps
`default_nettype none

module sram_selftest (
    input  wire                  pll_clk,
    input  wire                  rst_n,
    input  wire                  done,
    input  wire sram_pkg::byte_t data_out,
    input  wire                  data_out_empty,
    output sram_pkg::cmd_t       cmd,
    output sram_pkg::byte_t      data_in,
    output logic                 data_in_valid,
    output logic                 data_out_read,
    output sram_pkg::led_t       led
);

    typedef enum logic [2:0] {
        ST_INIT, ST_STUFF, ST_ISSUE_WRITE, ST_WAIT_WRITE,
        ST_ISSUE_READ, ST_WAIT_READ, ST_COMPARE, ST_FINISH
    } state_t;

    state_t          state;
    sram_pkg::len_t  cnt;
    sram_pkg::byte_t pattern;    // Seed plus cnt times step
    logic            mismatch;
    logic            bad;
    logic            last;

    // Pop each head byte in the cycle it is compared
    assign data_out_read = (state == ST_COMPARE) && !data_out_empty;
    assign bad  = data_out_empty || (data_out != pattern);
    assign last = (cnt == sram_pkg::len_t'(sram_pkg::TEST_LEN - 1));

    always_ff @(posedge pll_clk) begin
        if (!rst_n) begin
            state         <= ST_INIT;
            cmd           <= '0;
            data_in       <= '0;
            data_in_valid <= 1'b0;
            cnt           <= '0;
            pattern       <= sram_pkg::TEST_SEED;
            mismatch      <= 1'b0;
            led           <= sram_pkg::LED_IDLE;
        end else begin
            case (state)
                ST_INIT: begin
                    if (done) state <= ST_STUFF;    // EQIO finished
                end
                ST_STUFF: begin
                    data_in       <= pattern;
                    data_in_valid <= 1'b1;
                    pattern       <= pattern + sram_pkg::TEST_STEP;
                    cnt           <= last ? '0 : cnt + 6'd1;
                    if (last) state <= ST_ISSUE_WRITE;
                end
                ST_ISSUE_WRITE: begin
                    data_in_valid <= 1'b0;
                    cmd.write_cmd <= 1'b1;
                    cmd.address   <= sram_pkg::TEST_ADDR;
                    state         <= ST_WAIT_WRITE;
                end
                ST_WAIT_WRITE: begin
                    cmd.write_cmd <= 1'b0;
                    // done still high while the strobe is out
                    if (!cmd.write_cmd && done) state <= ST_ISSUE_READ;
                end
                ST_ISSUE_READ: begin
                    cmd.read_cmd <= 1'b1;
                    cmd.size     <= sram_pkg::len_t'(sram_pkg::TEST_LEN);
                    cmd.address  <= sram_pkg::TEST_ADDR;
                    pattern      <= sram_pkg::TEST_SEED;
                    state        <= ST_WAIT_READ;
                end
                ST_WAIT_READ: begin
                    cmd.read_cmd <= 1'b0;
                    if (!cmd.read_cmd && done) state <= ST_COMPARE;
                end
                ST_COMPARE: begin
                    mismatch <= mismatch || bad;
                    pattern  <= pattern + sram_pkg::TEST_STEP;
                    cnt      <= cnt + 6'd1;
                    if (last) begin
                        led   <= (mismatch || bad) ? sram_pkg::LED_FAIL : sram_pkg::LED_PASS;
                        state <= ST_FINISH;
                    end
                end
                default: begin
                    state <= ST_FINISH;    // Hold result until reset
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/sram_test_top.sv
`timescale 1ns/1ps
`default_nettype none

module sram_test_top (
    input  wire            pll_clk,
    input  wire            rst_n,
    inout  wire [3:0]      sio,
    output logic           cs,
    output logic           sck,
    output sram_pkg::led_t led
);

    sram_pkg::cmd_t  cmd;
    sram_pkg::byte_t data_in;
    sram_pkg::byte_t data_out;
    logic            data_in_valid;
    logic            data_out_read;
    logic            data_out_empty;
    logic            done;

    sram_selftest i_selftest (
        .pll_clk        (pll_clk),
        .rst_n          (rst_n),
        .done           (done),
        .data_out       (data_out),
        .data_out_empty (data_out_empty),
        .cmd            (cmd),
        .data_in        (data_in),
        .data_in_valid  (data_in_valid),
        .data_out_read  (data_out_read),
        .led            (led)
    );

    spi_sram i_sram (
        .pll_clk        (pll_clk),
        .rst_n          (rst_n),
        .cmd            (cmd),
        .data_in        (data_in),
        .data_in_valid  (data_in_valid),
        .data_out_read  (data_out_read),
        .done           (done),
        .data_out       (data_out),
        .data_out_empty (data_out_empty),
        .cs             (cs),
        .sck            (sck),
        .sio            (sio)
    );

endmodule

`default_nettype wire

//--- tb/sram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sram_model (
    input  wire               rst_n,
    input  wire               cs,
    input  wire               sck,
    inout  wire [3:0]         sio,
    input  wire signed [31:0] corrupt_index    // -1 for a clean read-back
);

    localparam int ADDR_BITS = 12;    // Upper address bits alias

    sram_pkg::byte_t mem [2**ADDR_BITS];
    sram_pkg::byte_t cur [16];
    sram_pkg::byte_t log_bytes [4][16];
    int              log_len [4];
    logic            log_spi [4];
    int              txn_cnt;
    logic            clk_err;
    logic            quad_mode;
    logic            active;
    logic            spi_clean;
    logic            read_phase;
    sram_pkg::byte_t shreg;
    sram_pkg::addr_t addr;
    int              bits;
    int              nbytes;
    int              nib;
    logic [3:0]      drive;
    logic            drive_en;

    assign sio = drive_en ? drive : 4'bzzzz;
    // Command, address and dummy byte are in
    assign read_phase = quad_mode && nbytes == 5 && cur[0] == sram_pkg::CMD_READ;

    task automatic clear_state();
        quad_mode = 1'b0;
        txn_cnt   = 0;
        clk_err   = 1'b0;
        active    = 1'b0;
        drive_en  = 1'b0;
        nbytes    = 0;
    endtask

    task automatic store_byte();
        sram_pkg::addr_t wa;
        bits = 0;
        if (nbytes < 16) cur[nbytes] = shreg;
        nbytes++;
        if (nbytes == 4) addr = {cur[1], cur[2], cur[3]};
        if (nbytes > 4 && cur[0] == sram_pkg::CMD_WRITE) begin
            wa = addr + sram_pkg::addr_t'(nbytes - 5);
            mem[wa[ADDR_BITS-1:0]] = shreg;
        end
    endtask

    initial begin
        for (int i = 0; i < 2**ADDR_BITS; i++) begin
            mem[i] = sram_pkg::byte_t'(i ^ (i >> 8));
        end
        clear_state();
    end

    always @(negedge rst_n) clear_state();    // Board power cycle

    always @(negedge cs) begin
        active    = 1'b1;
        bits      = 0;
        nbytes    = 0;
        nib       = 0;
        spi_clean = 1'b1;
    end

    // ----------------------------------------
    // Command decode on rising sck
    // ----------------------------------------
    always @(posedge sck) begin
        if (cs !== 1'b0) begin
            clk_err = 1'b1;    // Clock outside a transaction
        end else if (!read_phase) begin
            if (quad_mode) begin
                shreg = {shreg[3:0], sio};
                bits += 4;
            end else begin
                shreg = {shreg[6:0], sio[0]};
                bits += 1;
                if (sio[3:1] !== 3'bzzz) spi_clean = 1'b0;
            end
            if (bits == 8) store_byte();
        end
    end

    always @(negedge sck) begin : drive_nibble
        sram_pkg::byte_t b;
        sram_pkg::addr_t ra;
        if (cs === 1'b0 && read_phase) begin
            ra = addr + sram_pkg::addr_t'(nib / 2);
            b  = mem[ra[ADDR_BITS-1:0]];
            if (nib / 2 == corrupt_index) b = b ^ 8'h10;    // One flipped bit
            drive    = nib[0] ? b[3:0] : b[7:4];
            drive_en = 1'b1;
            nib++;
        end
    end

    always @(posedge cs) begin
        drive_en = 1'b0;
        if (active) begin
            if (txn_cnt < 4) begin
                log_len[txn_cnt] = nbytes;
                log_spi[txn_cnt] = !quad_mode && spi_clean;
                for (int k = 0; k < 16; k++) begin
                    log_bytes[txn_cnt][k] = cur[k];
                end
            end
            if (!quad_mode && nbytes == 1 && cur[0] == sram_pkg::CMD_EQIO) quad_mode = 1'b1;
            txn_cnt++;
            active = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_sram_test.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sram_test;

    localparam int          RUN_CYCLES     = 3 * (64 * 1 + 8 * 24);
    localparam int          TIMEOUT_CYCLES = 2 * RUN_CYCLES + 464;
    localparam logic [31:0] SEED           = 32'h7fe40307;

    logic                pll_clk;
    logic                rst_n;
    wire [3:0]           sio;
    wire                 cs;
    wire                 sck;
    wire sram_pkg::led_t led;
    logic signed [31:0]  corrupt_index;
    logic [31:0]         lfsr;
    int                  cycles;
    int                  runs_checked = 0;

    sram_test_top i_dut (
        .pll_clk (pll_clk),
        .rst_n   (rst_n),
        .sio     (sio),
        .cs      (cs),
        .sck     (sck),
        .led     (led)
    );

    sram_model i_model (
        .rst_n         (rst_n),
        .cs            (cs),
        .sck           (sck),
        .sio           (sio),
        .corrupt_index (corrupt_index)
    );

    always #20 pll_clk = !pll_clk;

    always @(posedge pll_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the self-test never finished", cycles);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    // ----------------------------------------
    // Reference and random source
    // ----------------------------------------
    function automatic sram_pkg::byte_t pattern_byte(input int i);
        return sram_pkg::byte_t'(sram_pkg::TEST_SEED + i * sram_pkg::TEST_STEP);
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int k = 0; k < n; k++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_byte(input string name, input sram_pkg::byte_t got,
                              input sram_pkg::byte_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s = %02h, expected %02h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_code(input string name, input sram_pkg::byte_t got,
                              input sram_pkg::byte_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s command = %02h, expected %02h",
                     $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_leds(input sram_pkg::led_t got, input sram_pkg::led_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: led = %b, expected %b", $time, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_lanes(input string name, input logic [3:0] got,
                               input logic [3:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Fail at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_address(input int txn);
        check_byte("address high", i_model.log_bytes[txn][1], 8'h00);
        check_byte("address mid", i_model.log_bytes[txn][2], 8'h11);
        check_byte("address low", i_model.log_bytes[txn][3], 8'h22);
    endtask

    task automatic check_run(input int run);
        sram_pkg::addr_t a;
        check_count("transactions", i_model.txn_cnt, 3);
        check_bit("sck outside cs", i_model.clk_err, 1'b0);
        check_bit("cs", cs, 1'b1);

        check_count("EQIO bytes", i_model.log_len[0], 1);
        check_code("EQIO", i_model.log_bytes[0][0], 8'h38);
        check_bit("EQIO on sio[0] alone", i_model.log_spi[0], 1'b1);

        check_count("write bytes", i_model.log_len[1], 4 + sram_pkg::TEST_LEN);
        check_code("write", i_model.log_bytes[1][0], 8'h02);
        check_address(1);
        for (int i = 0; i < sram_pkg::TEST_LEN; i++) begin
            check_byte($sformatf("write data %0d", i), i_model.log_bytes[1][4 + i],
                       pattern_byte(i));
        end

        check_count("read bytes", i_model.log_len[2], 5);    // Code, address, dummy
        check_code("read", i_model.log_bytes[2][0], 8'h03);
        check_address(2);
        for (int i = 0; i < sram_pkg::TEST_LEN; i++) begin
            a = 24'h001122 + sram_pkg::addr_t'(i);
            check_byte($sformatf("mem[%06h]", a), i_model.mem[a[11:0]], pattern_byte(i));
        end

        check_leds(led, (run == 0) ? 4'b0110 : 4'b0101);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (5) @(negedge pll_clk);
        check_bit("cs", cs, 1'b1);
        check_bit("sck", sck, 1'b0);
        check_bit("done", i_dut.done, 1'b0);
        check_lanes("sio", sio, 4'bzzzz);
        check_leds(led, 4'b1111);
        rst_n = 1'b1;
    endtask

    // ----------------------------------------
    // Stimulus and compare
    // ----------------------------------------
    initial begin : stimulus
        int pick;
        pll_clk       = 1'b0;
        rst_n         = 1'b0;
        corrupt_index = -1;
        cycles        = 0;
        lfsr          = SEED;
        apply_reset();
        wait (runs_checked == 1);

        @(negedge pll_clk);
        take_bits(3, pick);
        corrupt_index = pick;    // Bad byte on read-back
        $display("Second run corrupts read-back byte %0d", pick);
        apply_reset();
        wait (runs_checked == 2);

        $display("RESULT: PASS");
        $finish;
    end

    initial begin : compare
        for (int run = 0; run < 2; run++) begin
            do @(negedge pll_clk); while (led[3] !== 1'b0);
            check_run(run);
            runs_checked = run + 1;
            wait (rst_n === 1'b0);
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
logic/sram_pkg.sv
logic/byte_fifo.sv
logic/spi_shifter.sv
logic/sram_sequencer.sv
logic/spi_sram.sv
logic/sram_selftest.sv
logic/sram_test_top.sv
tb/sram_model.sv
tb/tb_sram_test.sv

//--- Bender.yml
package:
  name: sram_test

sources:
  - logic/sram_pkg.sv
  - logic/byte_fifo.sv
  - logic/spi_shifter.sv
  - logic/sram_sequencer.sv
  - logic/spi_sram.sv
  - logic/sram_selftest.sv
  - logic/sram_test_top.sv
  - target: simulation
    files:
      - tb/sram_model.sv
      - tb/tb_sram_test.sv
